/* project.f */
+incdir+hdl
hdl/sbuf_pkg.sv
hdl/sram_port_if.sv
hdl/sram_1r1w.sv
hdl/sbuf_wr_ctrl.sv
hdl/sbuf_rd_sched.sv
hdl/sbuf_top.sv
sim/sbuf_chk.sv
sim/tb_sbuf_top.sv

/* Makefile */
# verilator build and run of the staging buffer testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_sbuf_top
FLIST     := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
# lets the run go on after an assertion error so the testbench can report it
RUN_ARGS  := +verilator+error+limit+100
FAIL_MSG  := sim failed
PASS_MSG  := sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test FAILED, no verdict in $(LOG)"; exit 1; fi
	@echo "test PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_sbuf_top.sv */
// ====================
// testbench of the credit based staging buffer
// pushes only while holding an upstream credit, returns output credits at random
// phases: single push latency, random traffic, back-pressure, final drain
// ====================
`timescale 1ns/1ps
`include "sbuf_params.svh"

module tb_sbuf_top import sbuf_pkg::*; ();

   localparam int CLK_PERIOD = 10;
   localparam int N_RAND     = 200; // pushes in the random phase
   // back-pressure adds at most the depth plus the downstream credits
   localparam int N_PLAN     = 1 + N_RAND + `SBUF_DEPTH + `SBUF_OUT_CREDITS;

   logic        clk;
   logic        rst_n;
   logic        in_valid;
   sbuf_word_t  in_data;
   logic        in_credit;
   logic        out_valid;
   sbuf_word_t  out_data;
   logic        out_credit;

   sbuf_word_t  exp_q [$];      // reference model, words pushed but not yet delivered
   logic [15:0] lfsr;           // galois lfsr state
   int          up_credits;     // credits the sender holds
   int          pushes;         // words pushed so far
   int          in_credits_seen; // in_credit pulses so far
   int          delivered;      // words seen with out_valid
   int          returned;       // out_credit pulses sent
   logic        withhold;       // downstream keeps its credits
   logic [31:0] r;

   sbuf_top dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .out_credit (out_credit)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ====================
   // helpers
   // ====================
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      if (s[0]) return (s >> 1) ^ 16'hB400; // taps 16 14 13 11
      return s >> 1;
   endfunction

   // one lfsr step per bit taken
   task automatic draw_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic abort_run();
      $display("sim failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic report_mismatch(input string msg);
      $display("ERR %0t %s", $time, msg);
      abort_run();
   endtask

   // one clock of stimulus, inputs change 1 ns after the edge
   task automatic step(input logic try_push);
      logic [31:0] v;
      @(posedge clk);
      #1;
      in_valid   = 1'b0;
      out_credit = 1'b0;
      if (try_push && up_credits != 0) begin
         draw_bits(`SBUF_WID, v);
         in_valid = 1'b1;
         in_data  = v;
         exp_q.push_back(v);
         up_credits--;
         pushes++;
      end
      if (!withhold && delivered > returned) begin
         draw_bits(1, v); // downstream hands back a credit for a word it holds
         out_credit = v[0];
         returned  += v[0];
      end
   endtask

   // ====================
   // monitor
   // ====================
   always @(posedge clk) begin
      if (rst_n) begin
         if (in_credit) begin
            in_credits_seen++;
            up_credits++;
         end
         if (out_valid) begin
            assert (exp_q.size() != 0)
               else report_mismatch("out_valid while no word is outstanding");
            assert (out_data == exp_q[0])
               else report_mismatch($sformatf("out_data %h, expected %h", out_data, exp_q[0]));
            void'(exp_q.pop_front());
            delivered++;
         end
         assert (delivered - returned <= `SBUF_OUT_CREDITS)
            else report_mismatch("more words delivered than downstream credits allow");
         assert (up_credits <= `SBUF_DEPTH)
            else report_mismatch("in_credit returned more credits than were spent");
         if (dut.u_chk.errs != 0) begin
            $display("a concurrent assertion in sbuf_chk failed");
            abort_run();
         end
      end
   end

   // watchdog sized from the planned word count
   initial begin
      #(CLK_PERIOD * (40 * N_PLAN + 200));
      $display("watchdog expired, the run timed out before the final drain");
      abort_run();
   end

   // ====================
   // main sequence
   // ====================
   initial begin
      rst_n      = 1'b0;
      in_valid   = 1'b0;
      in_data    = '0;
      out_credit = 1'b0;
      withhold   = 1'b0;
      lfsr       = 16'd41533;
      up_credits = `SBUF_DEPTH;
      pushes = 0;
      in_credits_seen = 0;
      delivered = 0;
      returned = 0;
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // single push into the idle buffer, sbuf_chk checks the latency
      repeat (2) step(1'b0);
      step(1'b1);
      while (delivered < 1) step(1'b0);
      repeat (4) step(1'b0);

      while (pushes < 1 + N_RAND) begin
         draw_bits(2, r); // three pushes in four cycles on average
         step(r[1:0] != 2'b00);
      end

      // back-pressure, keep pushing until the sender runs dry and stays dry
      withhold = 1'b1;
      do begin
         while (up_credits != 0) step(1'b1);
         repeat (`SBUF_RL + 6) step(1'b0);
      end while (up_credits != 0);
      assert (exp_q.size() == `SBUF_DEPTH)
         else report_mismatch($sformatf("%0d words held under back-pressure", exp_q.size()));
      // reads only stop once every downstream credit is spent
      assert (delivered - returned == `SBUF_OUT_CREDITS)
         else report_mismatch($sformatf("%0d downstream credits spent under back-pressure",
                                        delivered - returned));

      withhold = 1'b0;
      while (exp_q.size() != 0) step(1'b0);
      repeat (`SBUF_RL + 6) step(1'b0);
      assert (in_credits_seen == pushes)
         else report_mismatch($sformatf("%0d in_credit pulses for %0d pushes",
                                        in_credits_seen, pushes));

      if (dut.u_chk.errs != 0) begin
         $display("a concurrent assertion in sbuf_chk failed");
         abort_run();
      end else begin
         $display("sim passed");
         $finish;
      end
   end

endmodule

/* sim/sbuf_chk.sv */
// ====================
// concurrent checks bound into sbuf_top
// peeks at the read scheduler for its credit count and pipeline state
// errs counts failures so the testbench can see them
// ====================
`timescale 1ns/1ps
`include "sbuf_params.svh"

module sbuf_chk import sbuf_pkg::*; (
   input logic                                   clk,
   input logic                                   rst_n,
   input logic                                   in_valid,
   input logic                                   in_credit,
   input logic                                   out_valid,
   input sbuf_ptr_t                              wr_ptr,
   input sbuf_ptr_t                              rd_ptr,
   input logic [$clog2(`SBUF_OUT_CREDITS+1)-1:0] credits, // downstream credits held
   input logic                                   rd_busy  // a read is somewhere in the pipe
);

   int errs; // bumped by every failing assertion below

   initial errs = 0;

   // push into an empty buffer with nothing in flight and a credit in hand
   sequence push_into_idle;
      in_valid && (wr_ptr == rd_ptr) && !rd_busy && (credits != '0);
   endsequence

   // ====================
   // reset and bounds
   // ====================
   a_reset: assert property (@(posedge clk) $rose(rst_n) |->
         (!out_valid && !in_credit && wr_ptr == '0 && rd_ptr == '0 &&
          credits == `SBUF_OUT_CREDITS))
      else begin $error("outputs or pointers not in reset state"); errs++; end

   a_occupancy: assert property (@(posedge clk) disable iff (!rst_n)
         sbuf_ptr_t'(wr_ptr - rd_ptr) <= `SBUF_DEPTH) // stored words never exceed the depth
      else begin $error("more words stored than slots"); errs++; end

   a_credits: assert property (@(posedge clk) disable iff (!rst_n)
         credits <= `SBUF_OUT_CREDITS)
      else begin $error("downstream credit count above its reset value"); errs++; end

   // ====================
   // end to end latency
   // ====================
   // push sampled at edge k, out_valid rises after edge k+RL+2 and is seen at k+RL+3
   a_latency: assert property (@(posedge clk) disable iff (!rst_n)
         push_into_idle |-> ##(`SBUF_RL + 3) out_valid)
      else begin $error("out_valid late after a push into an idle buffer"); errs++; end

   for (genvar j = 1; j <= `SBUF_RL + 2; j++) begin : g_quiet
      a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
            push_into_idle |-> ##j !out_valid) // nothing else can come out of an idle buffer
         else begin $error("out_valid early after a push into an idle buffer"); errs++; end
   end

endmodule

bind sbuf_top sbuf_chk u_chk (
   .clk       (clk),
   .rst_n     (rst_n),
   .in_valid  (in_valid),
   .in_credit (in_credit),
   .out_valid (out_valid),
   .wr_ptr    (wr_ptr),
   .rd_ptr    (rd_ptr),
   .credits   (u_rd.credits),
   .rd_busy   (u_rd.re_q || (u_rd.vld != '0))
);

/* hdl/sbuf_top.sv */
// ====================
// credit based staging buffer, top level
// upstream starts with SBUF_DEPTH credits and pushes only while holding one
// downstream must accept every out_valid word, it paces the buffer by out_credit
// push to out_valid is SBUF_RL + 2 cycles into an idle buffer
// ====================
`timescale 1ns/1ps
`include "sbuf_params.svh"

module sbuf_top import sbuf_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   // upstream side
   input  logic                 in_valid,   // push one word
   input  logic [`SBUF_WID-1:0] in_data,
   output logic                 in_credit,  // one-cycle pulse, one credit back to the sender
   // downstream side
   output logic                 out_valid,  // one word delivered, no back-pressure
   output logic [`SBUF_WID-1:0] out_data,
   input  logic                 out_credit  // one-cycle pulse, one credit back to the buffer
);

   sbuf_ptr_t wr_ptr; // write side pointer, tells the reader what is stored
   sbuf_ptr_t rd_ptr; // read side pointer, only watched for overflow

   sram_port_if sram_if (); // both sram ports

   // ====================
   // storage
   // ====================
   sram_1r1w u_mem (
      .clk   (clk),
      .rst_n (rst_n),
      .m     (sram_if.mem)
   );

   // ====================
   // write and read side
   // ====================
   sbuf_wr_ctrl u_wr (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (in_valid),
      .in_data  (in_data),
      .rd_ptr   (rd_ptr),
      .wr_ptr   (wr_ptr),
      .wr       (sram_if.wr)
   );

   sbuf_rd_sched u_rd (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr_ptr     (wr_ptr),
      .out_credit (out_credit),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .rd_ptr     (rd_ptr),
      .rd         (sram_if.rd)
   );

endmodule

/* hdl/sbuf_rd_sched.sv */
// ====================
// read side of the staging buffer
// a read is issued whenever a word is stored and a downstream credit is held
// out_valid has no ready, downstream must take every word it gave credit for
// in_credit returns one upstream credit the cycle after each issue
// ====================
`timescale 1ns/1ps
`include "sbuf_params.svh"

module sbuf_rd_sched import sbuf_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  sbuf_ptr_t  wr_ptr,     // write pointer from the write side
   input  logic       out_credit, // downstream hands back one credit
   output logic       in_credit,  // one upstream credit goes back
   output logic       out_valid,  // out_data holds a word this cycle
   output sbuf_word_t out_data,
   output sbuf_ptr_t  rd_ptr,     // next slot to be read
   sram_port_if.rd    rd
);

   // wide enough to hold the full reset count of credits
   localparam int CW = $clog2(`SBUF_OUT_CREDITS + 1);

   logic [CW-1:0]       credits; // downstream credits currently held
   logic                issue;   // read goes out at the coming edge
   logic                re_q;    // read request as seen by the sram
   sbuf_addr_t          radr_q;  // slot of that read
   logic [`SBUF_RL-1:0] vld;     // one bit per sram pipeline stage holding a read

   // ====================
   // issue decision
   // ====================

   // a credit arriving in the same cycle is not needed, a held one is enough
   assign issue = (rd_ptr != wr_ptr) && (credits != '0);

   // ====================
   // pointer, credits and read request
   // ====================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_ptr    <= '0;
         credits   <= CW'(`SBUF_OUT_CREDITS);
         re_q      <= 1'b0;
         in_credit <= 1'b0;
      end else begin
         re_q      <= issue; // address goes to the sram one edge after the decision
         in_credit <= issue; // slot is freed, the sram reads it at the next edge
         if (issue) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({out_credit, issue})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits; // both or neither cancel out
         endcase
      end
   end

   // read address has no reset, re_q keeps it from being used
   always_ff @(posedge clk) begin
      if (issue) begin
         radr_q <= ptr_adr(rd_ptr);
      end
   end

   assign rd.re   = re_q;
   assign rd.radr = radr_q;

   // ====================
   // reads in flight and output register
   // ====================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld       <= '0;
         out_valid <= 1'b0;
      end else begin
         vld[0] <= re_q; // matches the first sram stage loading
         for (int i = 1; i < `SBUF_RL; i++) begin
            vld[i] <= vld[i-1];
         end
         out_valid <= vld[`SBUF_RL-1]; // rdata belongs to a read this cycle
      end
   end

   // payload only moves when a read lands
   always_ff @(posedge clk) begin
      if (vld[`SBUF_RL-1]) begin
         out_data <= rd.rdata;
      end
   end

endmodule

/* hdl/sbuf_wr_ctrl.sv */
// ====================
// write side of the staging buffer
// the sender must respect its credits, a push is never refused here
// a push into a full buffer is only flagged in simulation
// ====================
`timescale 1ns/1ps

module sbuf_wr_ctrl import sbuf_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       in_valid, // push strobe from upstream
   input  sbuf_word_t in_data,  // push payload
   input  sbuf_ptr_t  rd_ptr,   // read pointer, only used to spot overflow
   output sbuf_ptr_t  wr_ptr,   // next slot to be written
   sram_port_if.wr    wr
);

   logic full; // every slot holds a word that has not been issued yet

   // same slot but opposite wrap means the writer has lapped the reader
   assign full = (wr_ptr[SBUF_AW] != rd_ptr[SBUF_AW]) &&
                 (ptr_adr(wr_ptr) == ptr_adr(rd_ptr));

   // ====================
   // sram write port
   // ====================

   // each push goes straight into the slot named by wr_ptr
   // so the word is committed on the same edge that samples the push
   assign wr.we    = in_valid;
   assign wr.wadr  = ptr_adr(wr_ptr); // wrap bit is dropped for the address
   assign wr.wdata = in_data;

   // ====================
   // write pointer
   // ====================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
      end else if (in_valid) begin
         wr_ptr <= wr_ptr + 1'b1; // wraps naturally at twice the depth
      end
   end

   // overflow check
   // the reader may have advanced already while the credit is still on its way
   // so this check is looser than the credit rule itself
   always @(posedge clk) begin
      if (rst_n && in_valid) begin
         assert (!full)
            else $error("push into a full staging buffer, sender ignored its credits");
      end
   end

endmodule

/* hdl/sram_1r1w.sv */
// ====================
// behavioral simple dual port ram, one write port and one read port
// the read data comes out of a pipeline of SBUF_RL registers
// a read of a slot written in the same cycle returns the old word
// the buffer never does that since reads trail the write by two edges
// ====================
`timescale 1ns/1ps
`include "sbuf_params.svh"

module sram_1r1w import sbuf_pkg::*; (
   input logic    clk,
   input logic    rst_n,
   sram_port_if.mem m
);

   sbuf_word_t mem [`SBUF_DEPTH]; // storage array, contents are undefined after reset

   // read pipeline, stage 0 holds the word picked by the last accepted read
   sbuf_word_t [`SBUF_RL-1:0] pipe;

   // ====================
   // write port
   // ====================
   always_ff @(posedge clk) begin
      if (m.we) begin
         mem[m.wadr] <= m.wdata; // word is visible to reads from the next edge on
      end
   end

   // ====================
   // read port
   // ====================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pipe <= '0;
      end else begin
         if (m.re) begin
            pipe[0] <= mem[m.radr]; // first stage only loads on a read
         end
         // later stages move every cycle, the scheduler tracks the valid bits
         for (int i = 1; i < `SBUF_RL; i++) begin
            pipe[i] <= pipe[i-1];
         end
      end
   end

   assign m.rdata = pipe[`SBUF_RL-1]; // last stage drives the port

endmodule

/* hdl/sram_port_if.sv */
// ====================
// write and read port of the simple dual port sram
// no byte enables, one word per access
// ====================
`timescale 1ns/1ps

interface sram_port_if import sbuf_pkg::*; ();

   logic       we;    // write enable, the write happens at the sampling edge
   sbuf_addr_t wadr;  // write slot
   sbuf_word_t wdata; // write payload
   logic       re;    // read enable, the address is sampled with it
   sbuf_addr_t radr;  // read slot
   sbuf_word_t rdata; // read data, valid SBUF_RL edges after re is sampled

   // write side of the buffer
   modport wr (output we, output wadr, output wdata);

   // read side of the buffer
   modport rd (output re, output radr, input rdata);

   // the memory itself
   modport mem (input we, input wadr, input wdata, input re, input radr, output rdata);

endinterface

/* hdl/sbuf_pkg.sv */
// ====================
// shared word and pointer types of the staging buffer
// pointers carry one wrap bit above the address so full and empty differ
// ====================
`include "sbuf_params.svh"

package sbuf_pkg;

   localparam int SBUF_AW = $clog2(`SBUF_DEPTH); // address bits of one slot

   typedef logic [`SBUF_WID-1:0] sbuf_word_t; // one payload word
   typedef logic [SBUF_AW-1:0]   sbuf_addr_t; // sram address
   typedef logic [SBUF_AW:0]     sbuf_ptr_t;  // wrap bit on top of the address

   // strips the wrap bit to get the slot a pointer names
   function automatic sbuf_addr_t ptr_adr(sbuf_ptr_t p);
      return p[SBUF_AW-1:0];
   endfunction

endpackage

/* hdl/sbuf_params.svh */
// ====================
// sizing of the credit based staging buffer
// SBUF_DEPTH must be a power of two
// the upstream sender starts with SBUF_DEPTH credits
// SBUF_RL of 1 and 2 are supported by the read pipeline
// ====================
`ifndef SBUF_PARAMS_SVH
`define SBUF_PARAMS_SVH

`define SBUF_WID          32 // data word width in bits
`define SBUF_DEPTH        16 // entries in the sram, also the upstream credit count
`define SBUF_RL           1  // sram read latency in cycles

// credits held toward downstream after reset
`define SBUF_OUT_CREDITS  4

`endif
